// ==== verification/phy_cmd_input.txt ====
# stimulus: cmd_word add_pause ddr_cke dqs_pattern
# expected: cmd_nop sequence_done pause_len phy_addr phy_bank ras cas we cke odt dq_tri dqs_tri dci_dis_dq dci_dis_dqs dqs_data buf_wr buf_rd buf_rst
# idle after reset
00000000 0 1 55 1 0 000 00000000 00 3 3 3 3 0 ff ff 1 1 00 0 0 0
# activate in slot 1, addr 1234 bank 5
24696110 0 1 55 0 0 234 091a1234 2d 1 3 3 3 0 ff ff 0 0 00 0 0 0
# NOP keeps calm address, reports pause length
008a8000 0 1 55 1 0 045 091a1234 2d 3 3 3 3 0 ff ff 1 1 00 0 0 0
# NOP with done bit
09fe0000 0 1 55 1 1 000 091a1234 2d 3 3 3 3 0 ff ff 1 1 00 0 0 0
# write in slot 0 with ODT, DQ and DQS enable rising, toggle, buffer write
0140dcf8 0 1 55 0 0 0a0 005000a0 1b 3 2 2 3 3 cc ee 0 1 55 1 0 0
# pause repeats previous flags, word ignored for outputs
02225104 1 1 55 0 0 111 005000a0 1b 3 3 3 3 3 00 00 0 1 55 1 0 0
# pause again, flags now from the read word, DQ and DQS falling
00000000 1 1 55 0 0 000 00888111 09 3 3 3 3 0 33 11 1 1 00 0 1 0
# NOP, both lane groups floating
00000000 0 1 55 1 0 000 00000000 00 3 3 3 3 0 ff ff 1 1 00 0 0 0
# WE in slot 1 with CKE disable and buffer reset
ffffcb01 0 1 55 0 0 000 3fffffff 3f 3 3 1 0 0 ff ff 1 1 00 0 0 1
# same word with ddr_cke low
ffffcb01 0 0 3c 0 0 000 3fffffff 3f 3 3 1 3 0 ff ff 1 1 00 0 0 1
# all command bits in slot 0, DQS only rising
00023870 0 1 a5 0 0 001 00008001 00 2 2 2 3 0 ff ee 0 0 a5 0 0 0
# DQS falling
00000000 0 1 a5 1 0 000 00008001 00 3 3 3 3 0 ff 11 1 1 00 0 0 0
00000000 0 1 a5 1 0 000 00008001 00 3 3 3 3 0 ff ff 1 1 00 0 0 0
# pause after NOPs uses the last real command's flags
00000000 1 1 55 0 0 000 00008001 00 3 3 3 3 0 ff ee 0 0 55 0 0 0
00000000 0 1 55 1 0 000 00000000 00 3 3 3 3 0 ff 11 1 1 00 0 0 0
00000000 0 1 55 1 0 000 00000000 00 3 3 3 3 0 ff ff 1 1 00 0 0 0

// ==== phy_cmd.f ====
rtl/phy_cmd_pkg.sv
rtl/cmd_decode.sv
rtl/cmd_slot_encode.sv
rtl/tri_sequencer.sv
rtl/phy_cmd_top.sv
verification/phy_cmd_checker.sv
verification/phy_cmd_tb.sv

// ==== Makefile ====
# Verilator build and run for the PHY command-word stage

VERILATOR   ?= verilator
TOP         ?= phy_cmd_tb
RTL_TOP     ?= phy_cmd_top
FILELIST    ?= phy_cmd.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing --assert -Wall
LINT_FLAGS  ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/phy_cmd_tb.sv ====
/*
 * Testbench for the DDR3 PHY command-word stage:
 * clock and reset, vectors read from a text file and driven on the
 * falling edge, immediate-assertion checks just before the rising edge
 */
`timescale 1ns/10ps

module phy_cmd_tb;

    localparam time HALF_PERIOD   = 50ns;
    localparam int  RST_CYCLES    = 5;
    localparam int  RST_TIMEOUT   = 50;      // cycles allowed for reset release
    localparam int  MAX_LINES     = 500;     // line-count bound on the file loop
    localparam int  PAUSE_W       = 10;
    localparam string VECTOR_FILE = "verification/phy_cmd_input.txt";

    // tri transition patterns, fixed for the whole run
    localparam logic [3:0] DQ_ON   = 4'hc;
    localparam logic [3:0] DQ_OFF  = 4'h3;
    localparam logic [3:0] DQS_ON  = 4'he;
    localparam logic [3:0] DQS_OFF = 4'h1;

    logic               mclk;
    logic               rst_in;
    logic [31:0]        cmd_word;
    logic               add_pause;
    logic               ddr_cke;
    logic [7:0]         dqs_pattern;
    logic               cmd_nop;
    logic               cmd_add_pause;
    logic [PAUSE_W-1:0] pause_len;
    logic               sequence_done;
    logic [29:0]        phy_addr;
    logic [5:0]         phy_bank;
    logic [1:0]         phy_ras;
    logic [1:0]         phy_cas;
    logic [1:0]         phy_we;
    logic [1:0]         phy_cke;
    logic [1:0]         phy_odt;
    logic [7:0]         dq_tri;
    logic [7:0]         dqs_tri;
    logic               dci_dis_dq;
    logic               dci_dis_dqs;
    logic [7:0]         dqs_data;
    logic               buf_wr;
    logic               buf_rd;
    logic               buf_rst;

    logic [63:0] exp_v[18];                  // expected columns of one line
    logic [31:0] in_word;
    logic        in_pause;
    logic        in_cke;
    logic [7:0]  in_pattern;

    phy_cmd_top #(
        .CMD_PAUSE_BITS (PAUSE_W),
        .CMD_DONE_BIT   (10)
    ) dut0 (
        .mclk (mclk), .rst_in (rst_in),
        .cmd_word (cmd_word), .add_pause (add_pause),
        .cmd_nop (cmd_nop), .cmd_add_pause (cmd_add_pause),
        .pause_len (pause_len), .sequence_done (sequence_done),
        .ddr_cke (ddr_cke), .dqs_pattern (dqs_pattern),
        .dq_tri_on_pattern (DQ_ON), .dq_tri_off_pattern (DQ_OFF),
        .dqs_tri_on_pattern (DQS_ON), .dqs_tri_off_pattern (DQS_OFF),
        .phy_addr (phy_addr), .phy_bank (phy_bank),
        .phy_ras (phy_ras), .phy_cas (phy_cas), .phy_we (phy_we),
        .phy_cke (phy_cke), .phy_odt (phy_odt),
        .dq_tri (dq_tri), .dqs_tri (dqs_tri),
        .dci_dis_dq (dci_dis_dq), .dci_dis_dqs (dci_dis_dqs),
        .dqs_data (dqs_data),
        .buf_wr (buf_wr), .buf_rd (buf_rd), .buf_rst (buf_rst)
    );

    always #(HALF_PERIOD) mclk = ~mclk;      // 100 ns period

    initial begin
        rst_in = 1'b1;
        repeat (RST_CYCLES) @(posedge mclk);
        @(negedge mclk);
        rst_in = 1'b0;
    end

    // prints the reason and stops the run
    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare_field(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        assert (act === exp) else begin
            stop_with_error($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_outputs();
        compare_field("cmd_nop",       exp_v[0],  64'(cmd_nop));
        compare_field("sequence_done", exp_v[1],  64'(sequence_done));
        compare_field("pause_len",     exp_v[2],  64'(pause_len));
        compare_field("phy_addr",      exp_v[3],  64'(phy_addr));
        compare_field("phy_bank",      exp_v[4],  64'(phy_bank));
        compare_field("phy_ras",       exp_v[5],  64'(phy_ras));
        compare_field("phy_cas",       exp_v[6],  64'(phy_cas));
        compare_field("phy_we",        exp_v[7],  64'(phy_we));
        compare_field("phy_cke",       exp_v[8],  64'(phy_cke));
        compare_field("phy_odt",       exp_v[9],  64'(phy_odt));
        compare_field("dq_tri",        exp_v[10], 64'(dq_tri));
        compare_field("dqs_tri",       exp_v[11], 64'(dqs_tri));
        compare_field("dci_dis_dq",    exp_v[12], 64'(dci_dis_dq));
        compare_field("dci_dis_dqs",   exp_v[13], 64'(dci_dis_dqs));
        compare_field("dqs_data",      exp_v[14], 64'(dqs_data));
        compare_field("buf_wr",        exp_v[15], 64'(buf_wr));
        compare_field("buf_rd",        exp_v[16], 64'(buf_rd));
        compare_field("buf_rst",       exp_v[17], 64'(buf_rst));
        // the word's own pause request sits in bit 1
        compare_field("cmd_add_pause", 64'(in_word[1]), 64'(cmd_add_pause));
    endtask

    initial begin
        int    fd;
        int    n;
        int    lines;
        int    waited;
        string line;
        mclk        = 1'b0;
        cmd_word    = '0;
        add_pause   = 1'b0;
        ddr_cke     = 1'b1;
        dqs_pattern = '0;
        lines       = 0;
        waited      = 0;

        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            stop_with_error("could not open the vector file");
        end

        while (rst_in !== 1'b0 && waited < RST_TIMEOUT) begin  // wait out reset
            @(negedge mclk);
            waited++;
        end
        if (rst_in !== 1'b0) begin
            stop_with_error("reset was never released");
        end

        while (!$feof(fd) && lines < MAX_LINES) begin
            line = "";
            n = $fgets(line, fd);
            lines++;
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;                    // blank or comment line
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        in_word, in_pause, in_cke, in_pattern,
                        exp_v[0], exp_v[1], exp_v[2], exp_v[3], exp_v[4], exp_v[5],
                        exp_v[6], exp_v[7], exp_v[8], exp_v[9], exp_v[10], exp_v[11],
                        exp_v[12], exp_v[13], exp_v[14], exp_v[15], exp_v[16], exp_v[17]);
            if (n != 22) begin
                stop_with_error($sformatf("malformed vector on line %0d", lines));
            end
            @(negedge mclk);
            cmd_word    = in_word;
            add_pause   = in_pause;
            ddr_cke     = in_cke;
            dqs_pattern = in_pattern;
            #(HALF_PERIOD - 5ns);            // just before the rising edge
            compare_outputs();
        end
        if (!$feof(fd)) begin
            stop_with_error("vector file longer than the line limit, run timed out");
        end
        $fclose(fd);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== verification/phy_cmd_checker.sv ====
/*
 * Concurrent assertions bound to the command-stage top level:
 * a done word puts no command on the pins, DQ and DQS
 * transition patterns only right after an enable change
 */
`timescale 1ns/10ps

module phy_cmd_checker (
    input logic       mclk,
    input logic       rst_in,
    input logic       sequence_done,
    input logic [1:0] phy_ras,
    input logic [1:0] phy_cas,
    input logic [1:0] phy_we,
    input logic [7:0] dq_tri,
    input logic       dq_tri_req,            // inverted DQ enable
    input logic [7:0] dqs_tri,
    input logic       dqs_tri_req            // inverted DQS enable
);

    // done word is a NOP in both half-cycle slots
    done_is_nop: assert property (@(posedge mclk) disable iff (rst_in)
        sequence_done |-> (phy_ras == 2'b11 && phy_cas == 2'b11 && phy_we == 2'b11))
        else $error("command on the pins with sequence_done");

    // mixed word is a transition pattern
    dq_pattern_on_change: assert property (@(posedge mclk) disable iff (rst_in)
        (dq_tri != 8'hff && dq_tri != 8'h00) |-> (dq_tri_req != $past(dq_tri_req)))
        else $error("dq_tri pattern without a DQ enable change");

    dqs_pattern_on_change: assert property (@(posedge mclk) disable iff (rst_in)
        (dqs_tri != 8'hff && dqs_tri != 8'h00) |-> (dqs_tri_req != $past(dqs_tri_req)))
        else $error("dqs_tri pattern without a DQS enable change");

endmodule

bind phy_cmd_top phy_cmd_checker chk0 (
    .mclk          (mclk),
    .rst_in        (rst_in),
    .sequence_done (sequence_done),
    .phy_ras       (phy_ras),
    .phy_cas       (phy_cas),
    .phy_we        (phy_we),
    .dq_tri        (dq_tri),
    .dq_tri_req    (dq_tri_req),
    .dqs_tri       (dqs_tri),
    .dqs_tri_req   (dqs_tri_req)
);

// ==== rtl/phy_cmd_top.sv ====
/*
 * DDR3 PHY command-word stage top level:
 * command decoder, two-slot encoder and the DQ and DQS
 * tri-state sequencers, all in the mclk domain
 */
`timescale 1ns/10ps

module phy_cmd_top
    import phy_cmd_pkg::*;
#(
    parameter int CMD_PAUSE_BITS = 10,           // pause length width
    parameter int CMD_DONE_BIT   = 10            // done flag address bit
) (
    input  logic                      mclk,
    input  logic                      rst_in,
    // command port
    input  cmd_word_t                 cmd_word,
    input  logic                      add_pause,
    output logic                      cmd_nop,
    output logic                      cmd_add_pause,
    output logic [CMD_PAUSE_BITS-1:0] pause_len,
    output logic                      sequence_done,
    // static controls
    input  logic                      ddr_cke,
    input  dqs_word_t                 dqs_pattern,
    input  tri_pattern_t              dq_tri_on_pattern,
    input  tri_pattern_t              dq_tri_off_pattern,
    input  tri_pattern_t              dqs_tri_on_pattern,
    input  tri_pattern_t              dqs_tri_off_pattern,
    // PHY drive words
    output addr_pair_t                phy_addr,
    output bank_pair_t                phy_bank,
    output pin_pair_t                 phy_ras,
    output pin_pair_t                 phy_cas,
    output pin_pair_t                 phy_we,
    output pin_pair_t                 phy_cke,
    output pin_pair_t                 phy_odt,
    output tri_word_t                 dq_tri,
    output tri_word_t                 dqs_tri,
    output logic                      dci_dis_dq,
    output logic                      dci_dis_dqs,
    output dqs_word_t                 dqs_data,
    // external buffer
    output logic                      buf_wr,
    output logic                      buf_rd,
    output logic                      buf_rst
);

    addr_t  addr_calm;                           // decoder -> encoder
    bank_t  bank_calm;
    rcw_t   rcw_cur;
    flags_t flags_cur;
    logic   dq_tri_req;                          // decoder -> sequencers
    logic   dqs_tri_req;

    cmd_decode #(
        .CMD_PAUSE_BITS (CMD_PAUSE_BITS),
        .CMD_DONE_BIT   (CMD_DONE_BIT)
    ) decode0 (
        .mclk          (mclk),
        .rst_in        (rst_in),
        .cmd_word      (cmd_word),
        .add_pause     (add_pause),
        .cmd_nop       (cmd_nop),
        .cmd_add_pause (cmd_add_pause),
        .pause_len     (pause_len),
        .sequence_done (sequence_done),
        .addr_calm     (addr_calm),
        .bank_calm     (bank_calm),
        .rcw_cur       (rcw_cur),
        .flags_cur     (flags_cur),
        .dq_tri_req    (dq_tri_req),
        .dqs_tri_req   (dqs_tri_req)
    );

    cmd_slot_encode encode0 (
        .addr_calm   (addr_calm),
        .bank_calm   (bank_calm),
        .rcw_cur     (rcw_cur),
        .flags_cur   (flags_cur),
        .ddr_cke     (ddr_cke),
        .dqs_pattern (dqs_pattern),
        .phy_addr    (phy_addr),
        .phy_bank    (phy_bank),
        .phy_ras     (phy_ras),
        .phy_cas     (phy_cas),
        .phy_we      (phy_we),
        .phy_cke     (phy_cke),
        .phy_odt     (phy_odt),
        .dci_dis_dq  (dci_dis_dq),
        .dci_dis_dqs (dci_dis_dqs),
        .dqs_data    (dqs_data),
        .buf_wr      (buf_wr),
        .buf_rd      (buf_rd),
        .buf_rst     (buf_rst)
    );

    // DQ lane group
    tri_sequencer dq_seq (
        .mclk        (mclk),
        .rst_in      (rst_in),
        .tri_req     (dq_tri_req),
        .on_pattern  (dq_tri_on_pattern),
        .off_pattern (dq_tri_off_pattern),
        .tri_out     (dq_tri)
    );

    // DQS lane group
    tri_sequencer dqs_seq (
        .mclk        (mclk),
        .rst_in      (rst_in),
        .tri_req     (dqs_tri_req),
        .on_pattern  (dqs_tri_on_pattern),
        .off_pattern (dqs_tri_off_pattern),
        .tri_out     (dqs_tri)
    );

endmodule

// ==== rtl/tri_sequencer.sv ====
/*
 * Tri-state sequencer for one lane group:
 * driven/floating state register and the 8-bit tri-state word,
 * steady level or on/off transition pattern for one cycle
 */
`timescale 1ns/10ps

module tri_sequencer
    import phy_cmd_pkg::*;
(
    input  logic         mclk,
    input  logic         rst_in,
    input  logic         tri_req,                // 1 = float this group
    input  tri_pattern_t on_pattern,             // used when starting to drive
    input  tri_pattern_t off_pattern,            // used when starting to float
    output tri_word_t    tri_out
);

    lane_state_e state;                          // last cycle's request
    lane_state_e req_state;

    assign req_state = tri_req ? LANE_FLOATING : LANE_DRIVEN;

    // output word for this cycle
    always_comb begin
        if (req_state == state) begin
            tri_out = {$bits(tri_word_t){tri_req}};   // steady, all bits equal
        end else if (state == LANE_FLOATING) begin
            tri_out = {on_pattern, on_pattern};       // floating -> driven
        end else begin
            tri_out = {off_pattern, off_pattern};     // driven -> floating
        end
    end

    // pattern lasts one cycle, state follows the request
    always_ff @(posedge mclk or posedge rst_in) begin
        if (rst_in) begin
            state <= LANE_FLOATING;              // lines float out of reset
        end else begin
            state <= req_state;
        end
    end

endmodule

// ==== rtl/cmd_slot_encode.sv ====
/*
 * Two-slot PHY drive word builder:
 * active-low command in the selected half-cycle slot,
 * duplicated address/bank/CKE/ODT, DCI disables,
 * DQS toggle data and external buffer strobes
 */
`timescale 1ns/10ps

module cmd_slot_encode
    import phy_cmd_pkg::*;
(
    input  addr_t      addr_calm,
    input  bank_t      bank_calm,
    input  rcw_t       rcw_cur,                  // active high, zero on NOP
    input  flags_t     flags_cur,
    input  logic       ddr_cke,                  // XOR-ed with CKE disable flag
    input  dqs_word_t  dqs_pattern,
    output addr_pair_t phy_addr,
    output bank_pair_t phy_bank,
    output pin_pair_t  phy_ras,
    output pin_pair_t  phy_cas,
    output pin_pair_t  phy_we,
    output pin_pair_t  phy_cke,
    output pin_pair_t  phy_odt,
    output logic       dci_dis_dq,
    output logic       dci_dis_dqs,
    output dqs_word_t  dqs_data,
    output logic       buf_wr,
    output logic       buf_rd,
    output logic       buf_rst
);

    rcw_t rcw_n;                                 // pin level, active low
    rcw_t slot1_rcw;
    rcw_t slot0_rcw;
    logic cke_lvl;
    logic odt_lvl;

    assign rcw_n = ~rcw_cur;

    // command in one half-cycle, NOP (all ones) in the other
    assign slot1_rcw = flags_cur[F_SEL] ? rcw_n : '1;
    assign slot0_rcw = flags_cur[F_SEL] ? '1 : rcw_n;

    assign phy_ras = {slot1_rcw[2], slot0_rcw[2]};
    assign phy_cas = {slot1_rcw[1], slot0_rcw[1]};
    assign phy_we  = {slot1_rcw[0], slot0_rcw[0]};

    // address, bank, cke and odt span the whole mclk cycle
    assign phy_addr = {addr_calm, addr_calm};
    assign phy_bank = {bank_calm, bank_calm};

    assign cke_lvl = flags_cur[F_CKE_DIS] ^ ddr_cke;
    assign odt_lvl = flags_cur[F_ODT];
    assign phy_cke = {cke_lvl, cke_lvl};
    assign phy_odt = {odt_lvl, odt_lvl};

    // write leveling runs with DCI on DQ and ODT on, so DQS DCI stays off
    assign dci_dis_dq  = ~flags_cur[F_DCI_EN];
    assign dci_dis_dqs = dci_dis_dq | odt_lvl;

    assign dqs_data = flags_cur[F_DQS_TOGGLE] ? dqs_pattern : '0; // quiet unless toggling

    // strobes to the external buffer
    assign buf_wr  = flags_cur[F_BUF_WR];
    assign buf_rd  = flags_cur[F_BUF_RD];
    assign buf_rst = flags_cur[F_BUF_RST];

endmodule

// ==== rtl/cmd_decode.sv ====
/*
 * Command word decoder:
 * field split, held flags for pause repeat, calm address/bank
 * hold registers, NOP, sequence-done and pause-length decode,
 * tri-state requests for the DQ and DQS lane groups
 */
`timescale 1ns/10ps

module cmd_decode
    import phy_cmd_pkg::*;
#(
    parameter int CMD_PAUSE_BITS = 10,           // address LSBs giving pause length
    parameter int CMD_DONE_BIT   = 10            // address bit flagging sequence end
) (
    input  logic                      mclk,
    input  logic                      rst_in,
    input  cmd_word_t                 cmd_word,
    input  logic                      add_pause,     // repeat previous flags with NOP
    output logic                      cmd_nop,
    output logic                      cmd_add_pause, // the word's own pause request
    output logic [CMD_PAUSE_BITS-1:0] pause_len,
    output logic                      sequence_done,
    output addr_t                     addr_calm,
    output bank_t                     bank_calm,
    output rcw_t                      rcw_cur,
    output flags_t                    flags_cur,
    output logic                      dq_tri_req,    // 1 = float DQ
    output logic                      dqs_tri_req    // 1 = float DQS
);

    addr_t  addr_in;                             // raw fields of the word
    bank_t  bank_in;
    rcw_t   rcw_in;
    flags_t flags_in;
    logic   done_bit;

    addr_t  addr_prev;                           // last non-NOP values
    bank_t  bank_prev;
    flags_t flags_prev;

    // split the word
    assign addr_in       = cmd_word[W_ADDR_LSB +: ADDR_W];
    assign bank_in       = cmd_word[W_BANK_LSB +: BANK_W];
    assign rcw_in        = cmd_word[W_RCW_LSB  +: RCW_W];
    assign cmd_add_pause = cmd_word[W_ADD_PAUSE];

    // flags packed from word bits 10..2 and 0, skipping add-pause
    always_comb begin
        flags_in               = '0;
        flags_in[F_ODT]        = cmd_word[W_ODT];
        flags_in[F_CKE_DIS]    = cmd_word[W_CKE_DIS];
        flags_in[F_SEL]        = cmd_word[W_SEL];
        flags_in[F_DQ_EN]      = cmd_word[W_DQ_EN];
        flags_in[F_DQS_EN]     = cmd_word[W_DQS_EN];
        flags_in[F_DQS_TOGGLE] = cmd_word[W_DQS_TOGGLE];
        flags_in[F_DCI_EN]     = cmd_word[W_DCI_EN];
        flags_in[F_BUF_WR]     = cmd_word[W_BUF_WR];
        flags_in[F_BUF_RD]     = cmd_word[W_BUF_RD];
        flags_in[F_BUF_RST]    = cmd_word[W_BUF_RST];
    end

    // inserted pause: NOP command, previous flags
    always_comb begin
        if (add_pause) begin
            rcw_cur   = '0;                      // zero rcw is a NOP
            flags_cur = flags_prev;
        end else begin
            rcw_cur   = rcw_in;
            flags_cur = flags_in;
        end
    end

    // an inserted pause does not count as a NOP word
    assign cmd_nop = (rcw_in == '0) && !add_pause;

    // hold registers, loaded on every real command
    always_ff @(posedge mclk or posedge rst_in) begin
        if (rst_in) begin
            addr_prev  <= '0;
            bank_prev  <= '0;
            flags_prev <= '0;
        end else if (!cmd_nop) begin
            addr_prev  <= addr_in;               // raw word, also during add_pause
            bank_prev  <= bank_in;
            flags_prev <= flags_in;
        end
    end

    // keep address/bank lines quiet across NOPs and pauses
    assign addr_calm = (cmd_nop || add_pause) ? addr_prev : addr_in;
    assign bank_calm = (cmd_nop || add_pause) ? bank_prev : bank_in;

    // NOP address field carries pause length and done bit
    assign done_bit      = addr_in[CMD_DONE_BIT];
    assign sequence_done = cmd_nop && done_bit;
    assign pause_len     = done_bit ? '0 : addr_in[CMD_PAUSE_BITS-1:0]; // no length with done

    // lane groups float when their enable is off
    assign dq_tri_req  = ~flags_cur[F_DQ_EN];
    assign dqs_tri_req = ~flags_cur[F_DQS_EN];

endmodule

// ==== rtl/phy_cmd_pkg.sv ====
/*
 * Shared definitions for the DDR3 PHY command-word stage:
 * widths, command-word bit positions, flag positions within the
 * repeatable flag set, vector typedefs and the lane-state enum
 */
package phy_cmd_pkg;

    localparam int CMD_WORD_W = 32;              // one command word per mclk
    localparam int ADDR_W     = 15;              // DDR3 address lines
    localparam int BANK_W     = 3;               // bank address lines
    localparam int RCW_W      = 3;               // ras, cas, we
    localparam int FLAGS_W    = 10;              // repeatable flags

    // field positions inside the command word
    localparam int W_ADDR_LSB   = 17;            // address 31..17
    localparam int W_BANK_LSB   = 14;            // bank 16..14
    localparam int W_RCW_LSB    = 11;            // ras/cas/we 13..11
    localparam int W_ODT        = 10;
    localparam int W_CKE_DIS    = 9;
    localparam int W_SEL        = 8;             // half-cycle slot select
    localparam int W_DQ_EN      = 7;
    localparam int W_DQS_EN     = 6;
    localparam int W_DQS_TOGGLE = 5;
    localparam int W_DCI_EN     = 4;
    localparam int W_BUF_WR     = 3;
    localparam int W_BUF_RD     = 2;
    localparam int W_ADD_PAUSE  = 1;             // not repeated on a pause
    localparam int W_BUF_RST    = 0;

    // positions inside flags_t (word bits 10..2 and 0, packed)
    localparam int F_ODT        = 9;
    localparam int F_CKE_DIS    = 8;
    localparam int F_SEL        = 7;
    localparam int F_DQ_EN      = 6;
    localparam int F_DQS_EN     = 5;
    localparam int F_DQS_TOGGLE = 4;
    localparam int F_DCI_EN     = 3;
    localparam int F_BUF_WR     = 2;
    localparam int F_BUF_RD     = 1;
    localparam int F_BUF_RST    = 0;

    typedef logic [CMD_WORD_W-1:0] cmd_word_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [2*ADDR_W-1:0]   addr_pair_t;  // {slot1, slot0}
    typedef logic [BANK_W-1:0]     bank_t;
    typedef logic [2*BANK_W-1:0]   bank_pair_t;  // {slot1, slot0}
    typedef logic [RCW_W-1:0]      rcw_t;        // active high {ras, cas, we}
    typedef logic [1:0]            pin_pair_t;   // {slot1, slot0}
    typedef logic [FLAGS_W-1:0]    flags_t;
    typedef logic [7:0]            tri_word_t;   // 1 = floating
    typedef logic [3:0]            tri_pattern_t;
    typedef logic [7:0]            dqs_word_t;

    // encoded so the state bit equals the tri-state level
    typedef enum logic {
        LANE_DRIVEN   = 1'b0,
        LANE_FLOATING = 1'b1
    } lane_state_e;

endpackage
